// File: load_buffer.f
rtl/ooo_pkg.sv
rtl/lb_alloc.sv
rtl/lb_slot.sv
rtl/lb_issue.sv
rtl/load_buffer.sv
tb/mem_model.sv
tb/tb_load_buffer.sv

// File: rtl/lb_alloc.sv
`timescale 1ns/1ps
`default_nettype none

module lb_alloc import ooo_pkg::*; #(
  parameter int LB_DEPTH = 3
) (
  input  logic                clk_in,
  input  logic                rst_in,

  // dispatch side
  input  logic                in_valid,
  input  lb_entry_t           in_entry,
  output logic                in_ready,

  // slot side
  input  logic [LB_DEPTH-1:0] slot_free_vec, // one bit per slot, high when free
  output logic [LB_DEPTH-1:0] alloc_we,      // one-hot write strobe
  output lb_entry_t           alloc_entry    // same entry goes to every slot
);

  logic [LB_DEPTH-1:0] pick_oh; // chosen free slot, one-hot
  logic                any_free;
  logic                fire;    // valid/ready transfer this cycle

  // highest free index wins, so slots fill top down
  always_comb begin
    pick_oh  = '0;
    any_free = 1'b0;
    for (int i = 0; i < LB_DEPTH; i++) begin
      if (slot_free_vec[i]) begin
        pick_oh    = '0; // later (higher) hit overrides
        pick_oh[i] = 1'b1;
        any_free   = 1'b1;
      end
    end
  end

  assign in_ready = any_free; // comb, no registered stall
  assign fire     = in_valid && in_ready;

  // steer the write to the chosen slot only on a real transfer
  assign alloc_we    = fire ? pick_oh : '0;
  assign alloc_entry = in_entry;

  // never two slots written with the same load
  assert property (@(posedge clk_in) disable iff (rst_in)
    $onehot0(alloc_we))
    else $error("lb_alloc: alloc_we not one-hot (%b)", alloc_we);

  // slot written this cycle must show occupied from the next edge
  assert property (@(posedge clk_in) disable iff (rst_in)
    (alloc_we != '0) |=> ((slot_free_vec & $past(alloc_we)) == '0))
    else $error("lb_alloc: written slot still free after write");

endmodule

`default_nettype wire

// File: rtl/lb_issue.sv
`timescale 1ns/1ps
`default_nettype none

module lb_issue import ooo_pkg::*; #(
  parameter int LB_DEPTH = 3
) (
  input  logic                clk_in,
  input  logic                rst_in,

  // slot side
  input  slot_state_t         slot_state [LB_DEPTH],
  input  lb_entry_t           slot_entry [LB_DEPTH],
  output logic [LB_DEPTH-1:0] slot_issue, // one-hot, slot goes busy
  output logic [LB_DEPTH-1:0] slot_done,  // one-hot, slot goes free

  // memory side, four-phase req/ack
  output logic                mem_req,
  output word_t               mem_addr,
  input  logic                mem_ack,
  input  word_t               mem_rdata,

  // writeback, always accepted
  output logic                result_valid,
  output load_result_t        result
);

  // handshake fsm
  typedef enum logic [1:0] {
    iss_idle    = 2'd0, // looking for a ready slot
    iss_request = 2'd1, // req high, waiting for ack
    iss_release = 2'd2, // req low, waiting for ack to drop
    iss_return  = 2'd3  // result_valid pulse
  } iss_state_t;

  iss_state_t          state_q;
  logic [LB_DEPTH-1:0] ready_vec;
  logic [LB_DEPTH-1:0] pick_oh;  // lowest ready slot
  lb_entry_t           pick_entry;
  logic [LB_DEPTH-1:0] cur_q;    // slot currently at memory
  word_t               addr_q;   // held stable for the whole req phase
  load_result_t        result_q;
  logic                start;    // new request this cycle

  always_comb begin
    for (int i = 0; i < LB_DEPTH; i++) begin
      ready_vec[i] = (slot_state[i] == slot_ready);
    end
  end

  // fixed priority, slot 0 highest
  // walk downward so the lowest hit is the last one written
  always_comb begin
    pick_oh    = '0;
    pick_entry = slot_entry[0];
    for (int i = LB_DEPTH - 1; i >= 0; i--) begin
      if (ready_vec[i]) begin
        pick_oh    = '0;
        pick_oh[i] = 1'b1;
        pick_entry = slot_entry[i];
      end
    end
  end

  assign start = (state_q == iss_idle) && (pick_oh != '0);

  assign slot_issue = start ? pick_oh : '0;
  // slot frees on the edge where ack is seen low
  assign slot_done  = ((state_q == iss_release) && !mem_ack) ? cur_q : '0;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state_q <= iss_idle;
      cur_q   <= '0;
    end else begin
      case (state_q)
        iss_idle: begin
          if (start) begin
            state_q <= iss_request;
            cur_q   <= pick_oh;
          end
        end
        iss_request: begin
          if (mem_ack) begin
            state_q <= iss_release; // data captured below
          end
        end
        iss_release: begin
          if (!mem_ack) begin
            state_q <= iss_return;
          end
        end
        iss_return: begin
          state_q <= iss_idle;
        end
        default: state_q <= iss_idle;
      endcase
    end
  end

  // payload capture
  always_ff @(posedge clk_in) begin
    if (start) begin
      addr_q          <= pick_entry.addr;
      result_q.rob_ix <= pick_entry.rob_ix;
    end
    if ((state_q == iss_request) && mem_ack) begin
      result_q.data <= mem_rdata; // rdata valid with ack
    end
  end

  assign mem_req      = (state_q == iss_request);
  assign mem_addr     = addr_q;
  assign result_valid = (state_q == iss_return); // one-cycle pulse
  assign result       = result_q;

  // address must not move while the memory may be sampling it
  assert property (@(posedge clk_in) disable iff (rst_in)
    (mem_req && $past(mem_req)) |-> (mem_addr == $past(mem_addr)))
    else $error("lb_issue: mem_addr changed during req (%h)", mem_addr);

  // four-phase rule, previous ack gone before a new req
  assert property (@(posedge clk_in) disable iff (rst_in)
    $rose(mem_req) |-> !mem_ack)
    else $error("lb_issue: req raised while ack still high");

endmodule

`default_nettype wire

// File: rtl/lb_slot.sv
`timescale 1ns/1ps
`default_nettype none

module lb_slot import ooo_pkg::*; (
  input  logic        clk_in,
  input  logic        rst_in,

  // from allocator
  input  logic        we,       // write a new load into this slot
  input  lb_entry_t   wr_entry,

  // from reorder buffer
  input  logic        can_load, // rob says this load may go

  // from issue block
  input  logic        issue,    // picked for memory this cycle
  input  logic        done,     // result returned, release slot

  output slot_state_t state,
  output lb_entry_t   entry
);

  slot_state_t state_q;
  slot_state_t state_d;
  lb_entry_t   entry_q; // payload, no reset

  // next-state logic
  always_comb begin
    state_d = state_q;
    case (state_q)
      slot_free: begin
        if (we) begin
          state_d = slot_wait;
        end
      end
      slot_wait: begin
        // grant is sampled, so ready shows one edge later
        if (can_load) begin
          state_d = slot_ready;
        end
      end
      slot_ready: begin
        if (issue) begin
          state_d = slot_busy; // at memory now
        end
      end
      slot_busy: begin
        if (done) begin
          state_d = slot_free;
        end
      end
      default: state_d = slot_free;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state_q <= slot_free;
    end else begin
      state_q <= state_d;
    end
  end

  // latch address and rob index on allocation
  always_ff @(posedge clk_in) begin
    if (we) begin
      entry_q <= wr_entry;
    end
  end

  assign state = state_q;
  assign entry = entry_q;

  // allocator must only target an empty slot
  assert property (@(posedge clk_in) disable iff (rst_in)
    we |-> (state_q == slot_free))
    else $error("lb_slot: write into occupied slot (state %s)", state_q.name());

  // issue block releases only the slot it sent out
  assert property (@(posedge clk_in) disable iff (rst_in)
    done |-> (state_q == slot_busy))
    else $error("lb_slot: done outside busy (state %s)", state_q.name());

endmodule

`default_nettype wire

// File: rtl/load_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module load_buffer import ooo_pkg::*; #(
  parameter int LB_DEPTH = 3 // rob can_load width follows this
) (
  input  logic                clk_in,
  input  logic                rst_in,

  // dispatch
  input  logic                in_valid,
  input  lb_entry_t           in_entry,
  output logic                in_ready,

  // reorder buffer
  input  logic [LB_DEPTH-1:0] can_load,
  output rob_ix_t             slot_rob_ix [LB_DEPTH],
  output logic [LB_DEPTH-1:0] slot_occupied,

  // memory unit
  output logic                mem_req,
  output word_t               mem_addr,
  input  logic                mem_ack,
  input  word_t               mem_rdata,

  // writeback
  output logic                result_valid,
  output load_result_t        result
);

  logic [LB_DEPTH-1:0] slot_free_vec;
  logic [LB_DEPTH-1:0] alloc_we;
  lb_entry_t           alloc_entry;
  logic [LB_DEPTH-1:0] slot_issue;
  logic [LB_DEPTH-1:0] slot_done;
  slot_state_t         slot_state [LB_DEPTH];
  lb_entry_t           slot_entry [LB_DEPTH];

  lb_alloc #(.LB_DEPTH(LB_DEPTH)) u_alloc (
    .clk_in, .rst_in,
    .in_valid, .in_entry, .in_ready,
    .slot_free_vec, .alloc_we, .alloc_entry
  );

  for (genvar i = 0; i < LB_DEPTH; i++) begin : g_slot
    lb_slot u_slot (
      .clk_in, .rst_in,
      .we       (alloc_we[i]),
      .wr_entry (alloc_entry),
      .can_load (can_load[i]),
      .issue    (slot_issue[i]),
      .done     (slot_done[i]),
      .state    (slot_state[i]),
      .entry    (slot_entry[i])
    );

    assign slot_free_vec[i] = (slot_state[i] == slot_free);
    assign slot_occupied[i] = !slot_free_vec[i]; // busy counts as occupied
    assign slot_rob_ix[i]   = slot_entry[i].rob_ix;
  end

  lb_issue #(.LB_DEPTH(LB_DEPTH)) u_issue (
    .clk_in, .rst_in,
    .slot_state, .slot_entry, .slot_issue, .slot_done,
    .mem_req, .mem_addr, .mem_ack, .mem_rdata,
    .result_valid, .result
  );

endmodule

`default_nettype wire

// File: rtl/ooo_pkg.sv
package ooo_pkg;

  // widths that carry a meaning
  localparam int WORD_W   = 32;
  localparam int ROB_IX_W = 3; // 8-entry reorder buffer

  // data word or byte address
  typedef logic [WORD_W-1:0] word_t;

  // index into the reorder buffer
  typedef logic [ROB_IX_W-1:0] rob_ix_t;

  // one load as handed over by dispatch, also what a slot holds
  typedef struct packed {
    word_t   addr;   // computed load address
    rob_ix_t rob_ix; // owner in the reorder buffer
  } lb_entry_t;

  // loaded word on its way to writeback
  typedef struct packed {
    word_t   data;
    rob_ix_t rob_ix; // tag for the cdb / rob
  } load_result_t;

  // life of one buffer slot
  // free  -> wait  on alloc write
  // wait  -> ready once the rob grants can_load
  // ready -> busy  when picked for memory
  // busy  -> free  after the result went out
  typedef enum logic [1:0] {
    slot_free  = 2'd0,
    slot_wait  = 2'd1,
    slot_ready = 2'd2,
    slot_busy  = 2'd3
  } slot_state_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the load buffer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_load_buffer \
  -f load_buffer.f \
  --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Some tests failed" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
echo "simulation ok"

// File: tb/mem_model.sv
`timescale 1ns/1ps

module mem_model import ooo_pkg::*; (
  input  logic  clk_in,
  input  logic  rst_in,
  input  logic  mem_req,
  input  word_t mem_addr,
  output logic  mem_ack,
  output word_t mem_rdata
);

  localparam int SEED = 79594;

  logic [15:0] lfsr;
  logic [2:0]  wait_cnt;
  logic        counting; // delay already drawn for this req

  // x^16 + x^14 + x^13 + x^11 + 1, one new bit per call
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  always @(posedge clk_in) begin : respond
    logic [2:0] delay;
    if (rst_in) begin
      lfsr      = SEED[15:0]; // low 16 bits of the seed
      mem_ack   <= 1'b0;
      mem_rdata <= '0;
      wait_cnt  <= '0;
      counting  <= 1'b0;
    end else if (mem_req && !mem_ack) begin
      if (!counting) begin
        delay = '0;
        for (int b = 0; b < 3; b++) begin
          lfsr  = lfsr_step(lfsr);
          delay = {delay[1:0], lfsr[0]}; // 0..7 cycles
        end
        if (delay == 3'd0) begin
          mem_ack   <= 1'b1; // answer right away
          mem_rdata <= ~mem_addr;
        end else begin
          wait_cnt <= delay - 3'd1;
          counting <= 1'b1;
        end
      end else if (wait_cnt == 3'd0) begin
        mem_ack   <= 1'b1;
        mem_rdata <= ~mem_addr; // data is the inverted address
        counting  <= 1'b0;
      end else begin
        wait_cnt <= wait_cnt - 3'd1;
      end
    end else if (!mem_req && mem_ack) begin
      mem_ack <= 1'b0; // last phase, req gone
    end
  end

endmodule

// File: tb/tb_load_buffer.sv
`timescale 1ns/1ps

module tb_load_buffer import ooo_pkg::*; ();

  localparam int LB_DEPTH = 3;
  localparam int N_LOADS  = 8; // loads sent to memory over all tests
  localparam int TIMEOUT  = 40 * N_LOADS + 100;

  logic                clk_in;
  logic                rst_in;
  logic                in_valid;
  lb_entry_t           in_entry;
  logic                in_ready;
  logic [LB_DEPTH-1:0] can_load;
  rob_ix_t             slot_rob_ix [LB_DEPTH];
  logic [LB_DEPTH-1:0] slot_occupied;
  logic                mem_req;
  word_t               mem_addr;
  logic                mem_ack;
  word_t               mem_rdata;
  logic                result_valid;
  load_result_t        result;

  int                  cycles;
  int                  n_checks;
  int                  n_errors;
  logic [LB_DEPTH-1:0] model_occ;               // expected occupancy
  lb_entry_t           model_entry [LB_DEPTH];  // expected slot contents

  load_buffer #(.LB_DEPTH(LB_DEPTH)) UUT (
    .clk_in, .rst_in,
    .in_valid, .in_entry, .in_ready,
    .can_load, .slot_rob_ix, .slot_occupied,
    .mem_req, .mem_addr, .mem_ack, .mem_rdata,
    .result_valid, .result
  );

  mem_model u_mem (
    .clk_in, .rst_in,
    .mem_req, .mem_addr, .mem_ack, .mem_rdata
  );

  always #10 clk_in = ~clk_in; // 20 ns period

  // watchdog
  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Some tests failed");
      $finish;
    end
  end

  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      $display("Fail %s: got %h expected %h", name, got, exp);
      n_errors++;
    end
  endtask

  // allocator fills the highest free slot first
  function automatic int highest_free();
    for (int i = LB_DEPTH - 1; i >= 0; i--) begin
      if (!model_occ[i]) return i;
    end
    return -1;
  endfunction

  task automatic push_load(input word_t addr, input rob_ix_t ix);
    int slot;
    @(posedge clk_in);
    in_valid        <= 1'b1;
    in_entry.addr   <= addr;
    in_entry.rob_ix <= ix;
    @(negedge clk_in);
    while (!in_ready) @(negedge clk_in);
    slot = highest_free();
    @(posedge clk_in); // transfer edge
    in_valid <= 1'b0;
    model_occ[slot]          = 1'b1;
    model_entry[slot].addr   = addr;
    model_entry[slot].rob_ix = ix;
    @(negedge clk_in); // occupied one edge after accept
    check("slot_occupied", 64'(slot_occupied), 64'(model_occ));
    check("slot_rob_ix", 64'(slot_rob_ix[slot]), 64'(ix));
  endtask

  task automatic grant(input logic [LB_DEPTH-1:0] mask);
    @(posedge clk_in);
    can_load <= mask;
  endtask

  // next result pulse must belong to this slot
  task automatic expect_result(input int slot);
    word_t exp_data;
    exp_data = ~model_entry[slot].addr; // memory answers with the inverted address
    @(negedge clk_in);
    while (!result_valid) begin
      if (mem_req) begin
        check("mem_addr", 64'(mem_addr), 64'(model_entry[slot].addr));
      end
      @(negedge clk_in);
    end
    check("result.data", 64'(result.data), 64'(exp_data));
    check("result.rob_ix", 64'(result.rob_ix), 64'(model_entry[slot].rob_ix));
    model_occ[slot] = 1'b0; // freed at the same edge
    check("slot_occupied", 64'(slot_occupied), 64'(model_occ));
    check("in_ready", 64'(in_ready), 64'd1);
  endtask

  task automatic end_test(input string name, input int errs_before);
    $display("test %s finished with %0d errors", name, n_errors - errs_before);
  endtask

  task automatic test_reset();
    int e0;
    e0 = n_errors;
    @(negedge clk_in);
    check("in_ready", 64'(in_ready), 64'd1);
    check("mem_req", 64'(mem_req), 64'd0);
    check("result_valid", 64'(result_valid), 64'd0);
    check("slot_occupied", 64'(slot_occupied), 64'd0);
    end_test("reset", e0);
  endtask

  task automatic test_fill();
    int e0;
    e0 = n_errors;
    push_load(32'h1000_0040, 3'd5); // top slot
    push_load(32'h2000_0084, 3'd6);
    push_load(32'h3000_00c8, 3'd7);
    check("in_ready", 64'(in_ready), 64'd0); // full
    check("slot_rob_ix[2]", 64'(slot_rob_ix[2]), 64'd5);
    check("slot_rob_ix[1]", 64'(slot_rob_ix[1]), 64'd6);
    check("slot_rob_ix[0]", 64'(slot_rob_ix[0]), 64'd7);
    check("mem_req", 64'(mem_req), 64'd0); // nothing permitted yet
    end_test("fill", e0);
  endtask

  task automatic test_single();
    int e0;
    e0 = n_errors;
    grant(3'b010);
    expect_result(1);
    grant(3'b000);
    end_test("single", e0);
  endtask

  task automatic test_multi();
    int e0;
    e0 = n_errors;
    grant(3'b101); // lower slot of the two goes first
    expect_result(0);
    expect_result(2);
    grant(3'b000);
    end_test("multi", e0);
  endtask

  task automatic test_hold_refill();
    int e0;
    e0 = n_errors;
    push_load(32'h4000_0100, 3'd0);
    push_load(32'h5000_0144, 3'd1); // middle slot stays ungranted here
    push_load(32'h6000_0188, 3'd2);
    grant(3'b101);
    expect_result(0);
    expect_result(2);
    grant(3'b000);
    repeat (10) begin
      @(negedge clk_in);
      check("mem_req", 64'(mem_req), 64'd0); // slot 1 stays put
    end
    check("slot_occupied", 64'(slot_occupied), 64'(model_occ));
    push_load(32'h7000_01cc, 3'd3); // refills slot 2
    push_load(32'h8000_0210, 3'd4); // refills slot 0
    grant(3'b111);
    expect_result(0);
    expect_result(1);
    expect_result(2);
    grant(3'b000);
    @(negedge clk_in);
    check("slot_occupied", 64'(slot_occupied), 64'd0);
    end_test("hold_refill", e0);
  endtask

  initial begin
    clk_in    = 1'b0;
    rst_in    = 1'b1;
    in_valid  = 1'b0;
    in_entry  = '0;
    can_load  = '0;
    cycles    = 0;
    n_checks  = 0;
    n_errors  = 0;
    model_occ = '0;
    repeat (4) @(posedge clk_in);
    rst_in <= 1'b0;
    test_reset();
    test_fill();
    test_single();
    test_multi();
    test_hold_refill();
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule
